/* alu.sv */
/*
  integer ALU
  add, sub, logic ops, shifts, set-less-than, pass of operand b
  and the six branch conditions as a 0 or 1 result
*/

`timescale 1ns/1ps

module alu import cpuPkg::*; (
  input AluOp op,
  input Word  a,
  input Word  b,
  output Word result
);

  logic [4:0] shamt;

  // only the low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluSll:   result = a << shamt;
      aluSlt:   result = Word'($signed(a) < $signed(b));
      aluSltu:  result = Word'(a < b);
      aluXor:   result = a ^ b;
      aluSrl:   result = a >> shamt;
      aluSra:   result = Word'($signed(a) >>> shamt);
      aluOr:    result = a | b;
      aluAnd:   result = a & b;
      aluPassB: result = b;
      aluBeq:   result = Word'(a == b);
      aluBne:   result = Word'(a != b);
      aluBlt:   result = Word'($signed(a) < $signed(b));
      aluBge:   result = Word'($signed(a) >= $signed(b));
      aluBltu:  result = Word'(a < b);
      aluBgeu:  result = Word'(a >= b);
      default:  result = '0;
    endcase
  end

endmodule

/* cpu.f */
+incdir+.
cpuPkg.sv
decodeBus.sv
alu.sv
decoder.sv
registerFile.sv
dataMemory.sv
fetchUnit.sv
cpu.sv
cpu_properties.sv
cpu_tb.sv

/* cpu.sv */
/*
  two-stage RV32I core top level
  fetch unit, decoder, register file, ALU and data RAM
  operand and write-back selection, status and trace outputs
*/

`timescale 1ns/1ps

module cpu import cpuPkg::*; (
  input logic  clk,
  input logic  reset,
  input Word   inst,
  output Word  pcIf,
  output Word  pcId,
  output Word  nextPc,
  output logic flushId,
  output logic halt,
  output logic illegal,
  output logic wbEn,
  output RegId wbRd,
  output Word  wbData
);

  Word instId;
  Word rdata1;
  Word rdata2;
  Word aluA;
  Word aluB;
  Word aluResult;
  Word loadData;
  Word wbValue;

  decodeBus dec();

  fetchUnit fetch (
    .clk       (clk),
    .reset     (reset),
    .inst      (inst),
    .flags     (dec.flags),
    .aluResult (aluResult),
    .imm       (dec.imm),
    .pcIf      (pcIf),
    .pcId      (pcId),
    .nextPc    (nextPc),
    .instId    (instId),
    .flushId   (flushId)
  );

  decoder decode (
    .instId (instId),
    .bus    (dec.source)
  );

  registerFile regFile (
    .clk    (clk),
    .reset  (reset),
    .rs1    (dec.rs1),
    .rs2    (dec.rs2),
    .rd     (dec.rd),
    .wen    (dec.flags.regWen),
    .wdata  (wbValue),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  // pc relative for auipc and jal, immediate unless register-register
  assign aluA = (dec.flags.isAuipc | dec.flags.isJal) ? pcId : rdata1;
  assign aluB = dec.flags.needImm ? dec.imm : rdata2;

  alu execute (
    .op     (dec.aluOp),
    .a      (aluA),
    .b      (aluB),
    .result (aluResult)
  );

  dataMemory dataMem (
    .clk   (clk),
    .addr  (aluResult),
    .wdata (rdata2),
    .bus   (dec.sink),
    .rdata (loadData)
  );

  // link address for jumps
  always_comb begin
    if (dec.flags.isJal | dec.flags.isJalr) begin
      wbValue = pcId + Word'(4);
    end else if (dec.flags.isLoad) begin
      wbValue = loadData;
    end else begin
      wbValue = aluResult;
    end
  end

  assign halt = dec.flags.isEbreak;
  assign illegal = dec.flags.notImpl;

  // trace of the instruction retiring this cycle
  assign wbEn = dec.flags.regWen && (dec.rd != '0);
  assign wbRd = dec.rd;
  assign wbData = wbValue;

endmodule

/* cpuPkg.sv */
/*
  shared types of the core
  word, register id, opcode, ALU op and access width enums,
  control flag struct and the instruction word union
*/

`include "cpu_config.svh"

package cpuPkg;

  typedef logic [`DataWidth-1:0] Word;
  typedef logic [`RegIdWidth-1:0] RegId;

  // base opcodes handled by the decoder
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011,
    opSystem = 7'b1110011
  } Opcode;

  typedef enum logic [4:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluSra, aluOr, aluAnd,
    aluPassB, aluBeq, aluBne, aluBlt, aluBge, aluBltu, aluBgeu
  } AluOp;

  // encoding follows funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    memByte = 2'b00,
    memHalf = 2'b01,
    memWord = 2'b10
  } MemWidth;

  typedef struct packed {
    logic regWen;
    logic needImm;
    logic isLoad;
    logic memWen;
    logic isUnsigned;
    logic isBranch;
    logic isJal;
    logic isJalr;
    logic isAuipc;
    logic isEbreak;
    logic notImpl;
  } CtrlFlags;

  typedef struct packed {
    logic [6:0] funct7;
    RegId       rs2;
    RegId       rs1;
    logic [2:0] funct3;
    RegId       rd;
    Opcode      opcode;
  } RType;

  typedef struct packed {
    logic [11:0] imm;
    RegId        rs1;
    logic [2:0]  funct3;
    RegId        rd;
    Opcode       opcode;
  } IType;

  typedef struct packed {
    logic [6:0] immHi;
    RegId       rs2;
    RegId       rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    Opcode      opcode;
  } SType;

  typedef struct packed {
    logic [19:0] imm;
    RegId        rd;
    Opcode       opcode;
  } UType;

  // one instruction word, several field layouts
  typedef union packed {
    RType rType;
    IType iType;
    SType sType;
    UType uType;
  } InstWord;

endpackage

/* cpu_config.svh */
/*
  core configuration macros
  word and register id widths, reset program counter,
  data memory depth in words and the NOP encoding
*/

`ifndef CpuConfigSvh
`define CpuConfigSvh

// datapath word width
`define DataWidth 32

`define RegIdWidth 5

// first fetch address after reset
`define PcReset 32'h0000_0000

`define DataMemWords 256

// addi x0, x0, 0
`define NopInst 32'h0000_0013

`endif

/* cpu_properties.sv */
/*
  concurrent checks on the core top level
  x0 never traced, redirect lands on the previous nextPc,
  sequential next PC, quiet status right after reset
*/

`timescale 1ns/1ps

module cpuProperties import cpuPkg::*; (
  input logic clk,
  input logic reset,
  input Word  pcIf,
  input Word  nextPc,
  input logic flushId,
  input logic halt,
  input logic illegal,
  input logic wbEn,
  input RegId wbRd
);

  noX0Write: assert property (@(posedge clk) disable iff (reset) wbEn |-> wbRd != '0)
    else $error("write-back strobe raised with x0 as destination");

  // redirect target taken on the following edge
  redirectTarget: assert property (@(posedge clk) disable iff (reset)
    flushId && !halt |=> pcIf == $past(nextPc))
    else $error("pcIf did not load the redirect target");

  seqNextPc: assert property (@(posedge clk) disable iff (reset)
    !flushId && !halt |-> nextPc == pcIf + 32'd4)
    else $error("nextPc is not pcIf plus 4 without a redirect");

  quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> !halt && !illegal)
    else $error("halt or illegal raised right after reset");

endmodule

bind cpu cpuProperties props (
  .clk     (clk),
  .reset   (reset),
  .pcIf    (pcIf),
  .nextPc  (nextPc),
  .flushId (flushId),
  .halt    (halt),
  .illegal (illegal),
  .wbEn    (wbEn),
  .wbRd    (wbRd)
);

/* cpu_tb.sv */
/*
  testbench for the two-stage core
  clock and reset, instruction server driven from pcIf,
  program and retirement trace tables, compare tasks, timeout
*/

`timescale 1ns/1ps

`include "cpu_config.svh"

module cpuTb import cpuPkg::*; ();

  // six taken branches plus jal and jalr
  localparam int ExpRedirects = 8;
  localparam int HaltHoldCycles = 5;

  logic clk;
  logic reset;
  Word  inst;
  Word  pcIf;
  Word  pcId;
  Word  nextPc;
  logic flushId;
  logic halt;
  logic illegal;
  logic wbEn;
  RegId wbRd;
  Word  wbData;

  Word   prog [$];
  string trName [$];
  RegId  trRd [$];
  Word   trData [$];
  bit    trJump [$];

  int  errors = 0;
  int  checks = 0;
  int  cycles = 0;
  int  limit = 0;
  int  traceIdx = 0;
  int  flushCount = 0;
  int  illegalCount = 0;
  int  haltCycles = 0;
  Word haltPc = '0;
  bit  done = 1'b0;

  cpu DUT (
    .clk     (clk),
    .reset   (reset),
    .inst    (inst),
    .pcIf    (pcIf),
    .pcId    (pcId),
    .nextPc  (nextPc),
    .flushId (flushId),
    .halt    (halt),
    .illegal (illegal),
    .wbEn    (wbEn),
    .wbRd    (wbRd),
    .wbData  (wbData)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // instruction encoders in assembly operand order
  function automatic Word regOp(input Word f7, input Word f3, input Word rd, input Word rs1,
                                input Word rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opReg};
  endfunction

  function automatic Word immOp(input Opcode opc, input Word f3, input Word rd, input Word rs1,
                                input Word imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic Word storeOp(input Word f3, input Word rs2, input Word rs1, input Word imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opStore};
  endfunction

  function automatic Word branchOp(input Word f3, input Word rs1, input Word rs2, input Word imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
  endfunction

  function automatic Word upperOp(input Opcode opc, input Word rd, input Word imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic Word jumpOp(input Word rd, input Word imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
  endfunction

  task automatic append(input Word w);
    prog.push_back(w);
  endtask

  // instruction plus the write-back it must retire with
  task automatic expectWb(input Word w, input string name, input RegId rd, input Word data,
                          input bit jump);
    prog.push_back(w);
    trName.push_back(name);
    trRd.push_back(rd);
    trData.push_back(data);
    trJump.push_back(jump);
  endtask

  task automatic buildProgram();
    expectWb(immOp(opImm, 0, 1, 0, 5), "addi x1", 1, 32'h0000_0005, 0);
    expectWb(immOp(opImm, 0, 2, 0, -3), "addi x2", 2, 32'hFFFF_FFFD, 0);
    expectWb(regOp(0, 0, 3, 1, 2), "add", 3, 32'h0000_0002, 0);
    expectWb(regOp(7'h20, 0, 4, 1, 2), "sub", 4, 32'h0000_0008, 0);
    expectWb(immOp(opImm, 1, 5, 1, 3), "slli", 5, 32'h0000_0028, 0);
    expectWb(immOp(opImm, 5, 6, 2, 32'h401), "srai", 6, 32'hFFFF_FFFE, 0);
    expectWb(immOp(opImm, 5, 7, 2, 28), "srli", 7, 32'h0000_000F, 0);
    expectWb(regOp(0, 2, 8, 2, 1), "slt", 8, 32'h0000_0001, 0);
    expectWb(regOp(0, 3, 9, 2, 1), "sltu", 9, 32'h0000_0000, 0);
    expectWb(immOp(opImm, 2, 10, 2, -2), "slti", 10, 32'h0000_0001, 0);
    expectWb(immOp(opImm, 3, 11, 1, -1), "sltiu", 11, 32'h0000_0001, 0);
    expectWb(immOp(opImm, 4, 12, 1, 32'hF0), "xori", 12, 32'h0000_00F5, 0);
    expectWb(regOp(0, 6, 13, 1, 2), "or", 13, 32'hFFFF_FFFD, 0);
    expectWb(regOp(0, 7, 14, 1, 2), "and", 14, 32'h0000_0005, 0);
    expectWb(upperOp(opLui, 15, 32'h12345), "lui", 15, 32'h1234_5000, 0);
    // pc 0x3c
    expectWb(upperOp(opAuipc, 16, 1), "auipc", 16, 32'h0000_103C, 0);
    expectWb(regOp(0, 1, 17, 1, 1), "sll", 17, 32'h0000_00A0, 0);
    expectWb(regOp(7'h20, 5, 18, 2, 1), "sra", 18, 32'hFFFF_FFFF, 0);
    expectWb(regOp(0, 5, 19, 2, 1), "srl", 19, 32'h07FF_FFFF, 0);
    expectWb(immOp(opImm, 6, 20, 1, 32'h00A), "ori", 20, 32'h0000_000F, 0);
    expectWb(immOp(opImm, 7, 21, 2, 32'h0F0), "andi", 21, 32'h0000_00F0, 0);
    expectWb(regOp(0, 4, 22, 1, 2), "xor", 22, 32'hFFFF_FFF8, 0);
    // data word at 0x40
    expectWb(immOp(opImm, 0, 23, 0, 32'h40), "addi base", 23, 32'h0000_0040, 0);
    expectWb(upperOp(opLui, 24, 32'h89ABD), "lui data", 24, 32'h89AB_D000, 0);
    expectWb(immOp(opImm, 0, 24, 24, -529), "addi data", 24, 32'h89AB_CDEF, 0);
    append(storeOp(2, 24, 23, 0));
    expectWb(immOp(opLoad, 2, 25, 23, 0), "lw", 25, 32'h89AB_CDEF, 0);
    expectWb(immOp(opLoad, 0, 26, 23, 3), "lb", 26, 32'hFFFF_FF89, 0);
    expectWb(immOp(opLoad, 4, 27, 23, 3), "lbu", 27, 32'h0000_0089, 0);
    expectWb(immOp(opLoad, 1, 28, 23, 2), "lh", 28, 32'hFFFF_89AB, 0);
    expectWb(immOp(opLoad, 5, 29, 23, 0), "lhu", 29, 32'h0000_CDEF, 0);
    append(storeOp(0, 1, 23, 1));
    append(storeOp(1, 2, 23, 2));
    expectWb(immOp(opLoad, 2, 25, 23, 0), "lw after sb sh", 25, 32'hFFFD_05EF, 0);
    expectWb(immOp(opLoad, 0, 26, 23, 1), "lb after sb", 26, 32'h0000_0005, 0);
    expectWb(immOp(opLoad, 1, 27, 23, 0), "lh after sb", 27, 32'h0000_05EF, 0);
    // taken branches that each skip a write of x31
    append(branchOp(0, 1, 1, 8));
    append(immOp(opImm, 0, 31, 0, 32'h555));
    append(branchOp(1, 1, 2, 8));
    append(immOp(opImm, 0, 31, 0, 32'h555));
    append(branchOp(4, 2, 1, 8));
    append(immOp(opImm, 0, 31, 0, 32'h555));
    append(branchOp(5, 1, 2, 8));
    append(immOp(opImm, 0, 31, 0, 32'h555));
    append(branchOp(6, 1, 2, 8));
    append(immOp(opImm, 0, 31, 0, 32'h555));
    append(branchOp(7, 2, 1, 8));
    append(immOp(opImm, 0, 31, 0, 32'h555));
    // not taken
    append(branchOp(0, 1, 2, 8));
    append(branchOp(1, 1, 1, 8));
    append(branchOp(4, 1, 2, 8));
    append(branchOp(5, 2, 1, 8));
    append(branchOp(6, 2, 1, 8));
    append(branchOp(7, 1, 2, 8));
    expectWb(immOp(opImm, 0, 30, 0, 1), "fall through", 30, 32'h0000_0001, 0);
    // jal at 0xdc and jalr at 0xe8 to odd 0xf1
    expectWb(jumpOp(1, 8), "jal", 1, 32'h0000_00E0, 1);
    append(immOp(opImm, 0, 31, 0, 32'h555));
    expectWb(immOp(opImm, 0, 5, 0, 32'hF1), "addi target", 5, 32'h0000_00F1, 0);
    expectWb(immOp(opJalr, 0, 6, 5, 0), "jalr", 6, 32'h0000_00EC, 1);
    append(immOp(opImm, 0, 31, 0, 32'h555));
    append(immOp(opImm, 0, 0, 0, 123));
    expectWb(regOp(0, 6, 7, 0, 0), "read x0", 7, 32'h0000_0000, 0);
    append(32'hFFFF_FFFF);
    expectWb(regOp(0, 0, 8, 31, 0), "x31 untouched", 8, 32'h0000_0000, 0);
    // ebreak at 0x100 with a word behind it that must never retire
    append(32'h0010_0073);
    append(immOp(opImm, 0, 9, 0, 7));
  endtask

  function automatic Word instAt(input Word pc);
    int idx;
    idx = pc[31:2];
    if (idx < prog.size()) begin
      return prog[idx];
    end
    return `NopInst;
  endfunction

  task automatic checkWord(input string name, input Word expected, input Word actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic checkReg(input string name, input RegId expected, input RegId actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected x%0d, got x%0d", name, expected, actual);
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %b, got %b", name, expected, actual);
    end
  endtask

  // sampled mid-cycle after the outputs have settled
  task automatic observeCycle();
    if (pcIf[1:0] != 2'b00) begin
      errors++;
      $display("fetch address %h is not word aligned", pcIf);
    end
    if (wbEn) begin
      if (traceIdx >= trName.size()) begin
        errors++;
        $display("unexpected write-back to x%0d from pc %h", wbRd, pcId);
      end else begin
        checkReg(trName[traceIdx], trRd[traceIdx], wbRd);
        checkWord(trName[traceIdx], trData[traceIdx], wbData);
        checkBit(trName[traceIdx], trJump[traceIdx], flushId);
        traceIdx++;
      end
    end
    if (flushId) begin
      flushCount++;
    end
    if (illegal) begin
      illegalCount++;
    end
    if (halt) begin
      if (haltCycles == 0) begin
        haltPc = pcId;
      end else begin
        checkWord("pcId held on halt", haltPc, pcId);
      end
      haltCycles++;
      done = (haltCycles >= HaltHoldCycles);
    end else if (haltCycles != 0) begin
      errors++;
      $display("halt dropped after %0d cycles", haltCycles);
      done = 1'b1;
    end
  endtask

  initial begin
    reset = 1'b1;
    inst = `NopInst;
    buildProgram();
    limit = 4 * prog.size() + 20;
    repeat (4) begin
      @(negedge clk);
      inst = instAt(pcIf);
    end
    reset = 1'b0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        errors++;
        $display("timeout, core did not stay halted within %0d cycles", limit);
        done = 1'b1;
      end else begin
        observeCycle();
        inst = instAt(pcIf);
      end
    end
    if (traceIdx != trName.size()) begin
      errors++;
      $display("only %0d of %0d expected write-backs were seen", traceIdx, trName.size());
    end
    checkWord("redirect cycles", Word'(ExpRedirects), Word'(flushCount));
    checkWord("illegal cycles", Word'(1), Word'(illegalCount));
    checkWord("ebreak pc", 32'h0000_0100, haltPc);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* dataMemory.sv */
/*
  data RAM
  word array with byte-lane writes for sb, sh and sw
  combinational loads with sign or zero extension
*/

`timescale 1ns/1ps

`include "cpu_config.svh"

module dataMemory import cpuPkg::*; (
  input logic    clk,
  input Word     addr,
  input Word     wdata,
  decodeBus.sink bus,
  output Word    rdata
);

  localparam int IndexBits = $clog2(`DataMemWords);

  Word                  mem [`DataMemWords];
  logic [IndexBits-1:0] index;
  logic [1:0]           offset;
  logic [3:0]           laneMask;
  Word                  laneData;
  Word                  rawWord;
  logic [7:0]           loadByte;
  logic [15:0]          loadHalf;

  assign index = addr[IndexBits+1:2];
  assign offset = addr[1:0];

  // store data replicated so each lane sees its own byte
  always_comb begin
    case (bus.width)
      memByte: begin
        laneMask = 4'b0001 << offset;
        laneData = {4{wdata[7:0]}};
      end
      memHalf: begin
        laneMask = offset[1] ? 4'b1100 : 4'b0011;
        laneData = {2{wdata[15:0]}};
      end
      default: begin
        laneMask = 4'b1111;
        laneData = wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus.flags.memWen) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (laneMask[lane]) begin
          mem[index][lane*8 +: 8] <= laneData[lane*8 +: 8];
        end
      end
    end
  end

  assign rawWord = mem[index];
  assign loadByte = rawWord[offset*8 +: 8];
  assign loadHalf = rawWord[offset[1]*16 +: 16];

  always_comb begin
    case (bus.width)
      memByte: rdata = bus.flags.isUnsigned ? {24'b0, loadByte} : {{24{loadByte[7]}}, loadByte};
      memHalf: rdata = bus.flags.isUnsigned ? {16'b0, loadHalf} : {{16{loadHalf[15]}}, loadHalf};
      default: rdata = rawWord;
    endcase
  end

endmodule

/* decodeBus.sv */
/*
  decoded instruction bundle
  register ids, immediate, ALU op, access width and control flags
  source modport for the decoder, sink modport for the execute side
*/

`timescale 1ns/1ps

interface decodeBus import cpuPkg::*;;

  RegId     rd;
  RegId     rs1;
  RegId     rs2;
  Word      imm;
  AluOp     aluOp;
  MemWidth  width;
  CtrlFlags flags;

  modport source (
    output rd, rs1, rs2, imm, aluOp, width, flags
  );

  modport sink (
    input rd, rs1, rs2, imm, aluOp, width, flags
  );

endinterface

/* decoder.sv */
/*
  instruction decoder
  immediate generation for I, S, B, U and J formats,
  ALU op and access width selection, control flags
*/

`timescale 1ns/1ps

module decoder import cpuPkg::*; (
  input Word       instId,
  decodeBus.source bus
);

  InstWord    iw;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       altOp;
  Word        immI;
  Word        immS;
  Word        immB;
  Word        immU;
  Word        immJ;
  CtrlFlags   flags;
  AluOp       aluOp;
  MemWidth    width;
  Word        imm;

  assign iw = instId;
  assign funct3 = iw.rType.funct3;
  assign funct7 = iw.rType.funct7;
  assign altOp = (funct7 == 7'b0100000);

  // immediates, all sign extended from the top instruction bit
  assign immI = {{20{iw.iType.imm[11]}}, iw.iType.imm};
  assign immS = {{20{iw.sType.immHi[6]}}, iw.sType.immHi, iw.sType.immLo};
  assign immB = {{20{iw.sType.immHi[6]}}, iw.sType.immLo[0], iw.sType.immHi[5:0],
                 iw.sType.immLo[4:1], 1'b0};
  assign immU = {iw.uType.imm, 12'b0};
  assign immJ = {{12{iw.uType.imm[19]}}, iw.uType.imm[7:0], iw.uType.imm[8],
                 iw.uType.imm[18:9], 1'b0};

  always_comb begin
    flags = '0;
    aluOp = aluAdd;
    width = memWord;
    imm = immI;
    case (iw.rType.opcode)
      opLui: begin
        flags.regWen = 1'b1;
        flags.needImm = 1'b1;
        aluOp = aluPassB;
        imm = immU;
      end
      opAuipc: begin
        flags.regWen = 1'b1;
        flags.needImm = 1'b1;
        flags.isAuipc = 1'b1;
        imm = immU;
      end
      opJal: begin
        flags.regWen = 1'b1;
        flags.needImm = 1'b1;
        flags.isJal = 1'b1;
        imm = immJ;
      end
      opJalr: begin
        flags.regWen = 1'b1;
        flags.needImm = 1'b1;
        flags.isJalr = 1'b1;
        flags.notImpl = (funct3 != 3'b000);
      end
      opBranch: begin
        flags.isBranch = 1'b1;
        imm = immB;
        case (funct3)
          3'b000: aluOp = aluBeq;
          3'b001: aluOp = aluBne;
          3'b100: aluOp = aluBlt;
          3'b101: aluOp = aluBge;
          3'b110: aluOp = aluBltu;
          3'b111: aluOp = aluBgeu;
          default: flags.notImpl = 1'b1;
        endcase
      end
      opLoad: begin
        flags.regWen = 1'b1;
        flags.needImm = 1'b1;
        flags.isLoad = 1'b1;
        flags.isUnsigned = funct3[2];
        width = MemWidth'(funct3[1:0]);
        // lwu and the reserved widths are outside RV32I
        flags.notImpl = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      opStore: begin
        flags.needImm = 1'b1;
        flags.memWen = 1'b1;
        imm = immS;
        width = MemWidth'(funct3[1:0]);
        flags.notImpl = funct3[2] || (funct3[1:0] == 2'b11);
      end
      opImm: begin
        flags.regWen = 1'b1;
        flags.needImm = 1'b1;
        case (funct3)
          3'b000: aluOp = aluAdd;
          3'b010: aluOp = aluSlt;
          3'b011: aluOp = aluSltu;
          3'b100: aluOp = aluXor;
          3'b110: aluOp = aluOr;
          3'b111: aluOp = aluAnd;
          3'b001: begin
            aluOp = aluSll;
            flags.notImpl = (funct7 != 7'b0);
          end
          default: begin
            aluOp = altOp ? aluSra : aluSrl;
            flags.notImpl = !altOp && (funct7 != 7'b0);
          end
        endcase
      end
      opReg: begin
        flags.regWen = 1'b1;
        case (funct3)
          3'b000: aluOp = altOp ? aluSub : aluAdd;
          3'b001: aluOp = aluSll;
          3'b010: aluOp = aluSlt;
          3'b011: aluOp = aluSltu;
          3'b100: aluOp = aluXor;
          3'b101: aluOp = altOp ? aluSra : aluSrl;
          3'b110: aluOp = aluOr;
          default: aluOp = aluAnd;
        endcase
        // funct7 alternate only exists for sub and sra
        flags.notImpl = !((funct7 == 7'b0) ||
                          (altOp && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      opSystem: begin
        flags.isEbreak = (instId == 32'h0010_0073);
        flags.notImpl = !flags.isEbreak;
      end
      default: flags.notImpl = 1'b1;
    endcase
    // unsupported words behave as a NOP
    if (flags.notImpl) begin
      flags = '0;
      flags.notImpl = 1'b1;
    end
  end

  assign bus.rd = iw.rType.rd;
  assign bus.rs1 = iw.rType.rs1;
  assign bus.rs2 = iw.rType.rs2;
  assign bus.imm = imm;
  assign bus.aluOp = aluOp;
  assign bus.width = width;
  assign bus.flags = flags;

endmodule

/* fetchUnit.sv */
/*
  fetch stage
  program counter, next PC selection, redirect flush
  and the fetch/decode register, frozen while ebreak sits in decode
*/

`timescale 1ns/1ps

`include "cpu_config.svh"

module fetchUnit import cpuPkg::*; (
  input logic     clk,
  input logic     reset,
  input Word      inst,
  input CtrlFlags flags,
  input Word      aluResult,
  input Word      imm,
  output Word     pcIf,
  output Word     pcId,
  output Word     nextPc,
  output Word     instId,
  output logic    flushId
);

  logic isJump;
  logic branchTaken;
  Word  instIf;

  assign isJump = flags.isJal | flags.isJalr;
  assign branchTaken = flags.isBranch && (aluResult == Word'(1));
  assign flushId = isJump | branchTaken;

  // jump target from the ALU, bit 0 cleared for jal too
  always_comb begin
    if (isJump) begin
      nextPc = aluResult & ~Word'(1);
    end else if (branchTaken) begin
      nextPc = pcId + imm;
    end else begin
      nextPc = pcIf + Word'(4);
    end
  end

  // the slot fetched behind a redirect becomes a bubble
  assign instIf = flushId ? `NopInst : inst;

  always_ff @(posedge clk) begin
    if (reset) begin
      pcIf <= `PcReset;
      pcId <= `PcReset;
      instId <= `NopInst;
    end else if (!flags.isEbreak) begin
      pcIf <= nextPc;
      pcId <= pcIf;
      instId <= instIf;
    end
  end

endmodule

/* registerFile.sv */
/*
  integer register file
  32 x 32 bits, x0 reads as zero
  two combinational read ports, one write port on the rising edge
*/

`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
  input logic clk,
  input logic reset,
  input RegId rs1,
  input RegId rs2,
  input RegId rd,
  input logic wen,
  input Word  wdata,
  output Word rdata1,
  output Word rdata2
);

  Word regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // no bypass, the writer has already left decode
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule
